//--- Bender.yml
package:
  name: tlb_mmu

export_include_dirs:
  - source

sources:
  - files:
      - source/mmu_pkg.sv
      - source/tlb_entry_array.sv
      - source/tlb_probe.sv
      - source/addr_xlate.sv
      - source/tlb_mmu.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/tlb_mmu_assert.sv
      - dv/tlb_mmu_tb.sv

//--- dv/tlb_mmu_assert.sv
// Bound assertions on the MMU top: reset state, response hold, probe index format
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_mmu_assert (
    input logic                clk,
    input logic                rst,
    input mmu_pkg::xlate_req_t req0_i,
    input mmu_pkg::xlate_req_t req1_i,
    input mmu_pkg::xlate_rsp_t rsp0_i,
    input mmu_pkg::xlate_rsp_t rsp1_i,
    input logic [31:0]         probe_index_i
);
    int fail_count = 0;

    a_rsp_reset: assert property (@(posedge clk)
        rst |=> !(rsp0_i.hit || rsp0_i.valid || rsp0_i.error ||
                  rsp1_i.hit || rsp1_i.valid || rsp1_i.error))
        else begin
            fail_count++;
            $error("response flags not cleared by reset");
        end

    a_hold0: assert property (@(posedge clk) disable iff (rst) !req0_i.ce |=> $stable(rsp0_i))
        else begin
            fail_count++;
            $error("rsp0 changed while ce was low");
        end

    a_hold1: assert property (@(posedge clk) disable iff (rst) !req1_i.ce |=> $stable(rsp1_i))
        else begin
            fail_count++;
            $error("rsp1 changed while ce was low");
        end

    // Miss leaves the index field zero
    a_probe_miss: assert property (@(posedge clk) disable iff (rst)
        probe_index_i[31] |-> (probe_index_i[`MMU_TLB_IDX_BITS-1:0] == '0))
        else begin
            fail_count++;
            $error("probe miss with nonzero index bits");
        end

endmodule

bind tlb_mmu tlb_mmu_assert u_assert (
    .clk           (clk),
    .rst           (rst),
    .req0_i        (req0_i),
    .req1_i        (req1_i),
    .rsp0_i        (rsp0_o),
    .rsp1_i        (rsp1_o),
    .probe_index_i (probe_index_o)
);

//--- dv/tlb_mmu_tb.sv
// MMU testbench with clock, LFSR stimulus, shadow TLB, reference model, compare process and report
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_mmu_tb;
    import mmu_pkg::*;

    localparam int num_entries = `MMU_TLB_NUM;
    localparam int n_xlate = 64;
    localparam int total_cycles = 5 + num_entries + 4 * num_entries + 2 * num_entries
                                  + (n_xlate + 2) + (24 + 2) + (9 + 2);

    logic        clk;
    logic        rst;
    logic        we_i;
    logic [31:0] index_i;
    logic [11:0] mask_i;
    logic [31:0] entryhi_i;
    logic [31:0] entrylo0_i;
    logic [31:0] entrylo1_i;
    cp0_mode_t   mode_i;
    xlate_req_t  req0_i;
    xlate_req_t  req1_i;
    logic [11:0] mask_o;
    logic [31:0] entryhi_o;
    logic [31:0] entrylo0_o;
    logic [31:0] entrylo1_o;
    logic [31:0] probe_index_o;
    xlate_rsp_t  rsp0_o;
    xlate_rsp_t  rsp1_o;

    tlb_entry_t  shadow [num_entries];
    logic [31:0] lfsr_q;
    int          err_total;
    int          err_at_start;
    int          tests_run;
    int          tests_failed;
    xlate_rsp_t  exp0;
    xlate_rsp_t  exp1;
    logic        pend0;
    logic        pend1;
    xlate_rsp_t  held;
    cp0_mode_t   mode_v;
    int          pick0;
    int          pick1;
    logic [31:0] va_a;
    logic [31:0] va_b;

    tlb_mmu dut0 (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // 4K up to 16M pages
    function automatic logic [11:0] legal_mask();
        logic [2:0] k;
        k = rand_bits(3);
        if (k == 3'd7) begin
            k = 3'd6;
        end
        return (12'h1 << (2 * k)) - 12'h1;
    endfunction

    function automatic xlate_rsp_t xlate_ref(input cp0_mode_t m, input logic [31:0] va,
                                             input logic [7:0] asid);
        xlate_rsp_t       r;
        address_segment_t s;
        logic             mapped;
        tlb_entry_t       e;
        int               ob;
        r = '0;
        r.vao = va;
        case (va[31:29])
            3'b100:  s = kseg0;
            3'b101:  s = kseg1;
            3'b110:  s = ksseg;
            3'b111:  s = kseg3;
            default: s = useg;
        endcase
        r.error = (s != useg) && !m.kernel_mode;
        if (s == useg) begin
            mapped = !(m.kernel_mode && m.erl);
        end else begin
            mapped = (s == ksseg || s == kseg3) && m.kernel_mode;
        end
        if (!mapped) begin
            r.pa = {3'b000, va[28:0]};
            r.hit = 1'b1;
            r.valid = 1'b1;
            r.dirty = 1'b1;
            r.cached = (s == kseg0) && m.kseg0_cached;
            return r;
        end
        r.pa = {20'b0, va[11:0]};
        for (int i = 0; i < num_entries; i++) begin
            e = shadow[i];
            if (((va[31:13] & ~{7'b0, e.mask}) == e.vpn2) && (e.g || e.asid == asid)) begin
                ob = 12;
                for (int b = 0; b < 12; b++) begin
                    if (e.mask[b]) begin
                        ob = 13 + b;
                    end
                end
                r.hit = 1'b1;
                r.pa[31:12] = (va[ob] ? e.pfn1 : e.pfn0) | (va[31:12] & {8'b0, e.mask});
                r.valid = va[ob] ? e.v1 : e.v0;
                r.dirty = va[ob] ? e.d1 : e.d0;
                r.cached = (va[ob] ? e.c1 : e.c0) == 3'd3;
            end
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
        if (got !== exp) begin
            err_total++;
            $display("Error at %0t ns: %s got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (err_total != err_at_start) begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, err_total - err_at_start);
        end else begin
            $display("Test %s: passed", name);
        end
        err_at_start = err_total;
    endtask

    task automatic write_random(input int idx);
        logic [11:0] m;
        logic [31:0] hi;
        logic [31:0] lo0;
        logic [31:0] lo1;
        m = legal_mask();
        hi = rand_bits(32);
        lo0 = rand_bits(32);
        lo1 = rand_bits(32);
        // Mapped segments only and vpn2[15:12] unique per entry
        if (hi[31]) begin
            hi[30] = 1'b1;
        end
        hi[28:25] = 4'(idx);
        @(negedge clk);
        we_i = 1'b1;
        index_i = rand_bits(32);
        index_i[`MMU_TLB_IDX_BITS-1:0] = tlb_idx_t'(idx);
        mask_i = m;
        entryhi_i = hi;
        entrylo0_i = lo0;
        entrylo1_i = lo1;
        @(negedge clk);
        we_i = 1'b0;
        shadow[idx] = '{mask: m, vpn2: hi[31:13] & ~{7'b0, m}, asid: hi[7:0],
                        g: lo0[0] & lo1[0], pfn0: lo0[25:6] & ~{8'b0, m},
                        pfn1: lo1[25:6] & ~{8'b0, m}, c0: lo0[5:3], c1: lo1[5:3],
                        d0: lo0[2], d1: lo1[2], v0: lo0[1], v1: lo1[1]};
    endtask

    // index_i must already select idx
    task automatic check_readback(input int idx);
        tlb_entry_t e;
        e = shadow[idx];
        @(posedge clk);
        check("mask_o", mask_o, e.mask);
        check("entryhi_o", entryhi_o, {e.vpn2, 5'b0, e.asid});
        check("entrylo0_o", entrylo0_o, {6'b0, e.pfn0, e.c0, e.d0, e.v0, e.g});
        check("entrylo1_o", entrylo1_o, {6'b0, e.pfn1, e.c1, e.d1, e.v1, e.g});
    endtask

    task automatic check_probe(input int idx);
        logic [18:0] vpn;
        logic [7:0]  wrong;
        vpn = shadow[idx].vpn2 | (19'(rand_bits(19)) & {7'b0, shadow[idx].mask});
        wrong = shadow[idx].asid ^ (8'(rand_bits(8)) | 8'h01);
        @(negedge clk);
        entryhi_i = {vpn, 5'(rand_bits(5)), shadow[idx].asid};
        @(posedge clk);
        check("probe_index_o", probe_index_o, idx);
        @(negedge clk);
        entryhi_i[7:0] = wrong;
        @(posedge clk);
        check("probe_index_o", probe_index_o, shadow[idx].g ? 32'(idx) : 32'h8000_0000);
    endtask

    task automatic drive_xlate(input cp0_mode_t m, input logic [7:0] asid,
                               input logic [31:0] va0, input logic ce0,
                               input logic [31:0] va1, input logic ce1);
        @(negedge clk);
        mode_i = m;
        entryhi_i[7:0] = asid;
        req0_i = '{va: va0, ce: ce0};
        req1_i = '{va: va1, ce: ce1};
    endtask

    task automatic drain();
        @(negedge clk);
        req0_i.ce = 1'b0;
        req1_i.ce = 1'b0;
        @(negedge clk);
    endtask

    function automatic logic [31:0] mapped_va(input int idx);
        logic [31:0] r;
        r = rand_bits(32);
        return {shadow[idx].vpn2 | (r[31:13] & {7'b0, shadow[idx].mask}), r[12:0]};
    endfunction

    // Expected value taken at the capturing edge and compared half a cycle later
    always begin
        @(posedge clk);
        pend0 = !rst && req0_i.ce;
        pend1 = !rst && req1_i.ce;
        exp0 = xlate_ref(mode_i, req0_i.va, entryhi_i[7:0]);
        exp1 = xlate_ref(mode_i, req1_i.va, entryhi_i[7:0]);
        @(negedge clk);
        if (pend0) begin
            check("rsp0_o", rsp0_o, exp0);
        end
        if (pend1) begin
            check("rsp1_o", rsp1_o, exp1);
        end
    end

    initial begin
        #(total_cycles * 15);
        $display("Timeout: tests did not finish within %0d cycles", total_cycles * 3 / 2);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        lfsr_q = 32'h7f16ab10;
        err_total = 0;
        err_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        rst = 1'b1;
        we_i = 1'b0;
        index_i = '0;
        mask_i = '0;
        entryhi_i = '0;
        entrylo0_i = '0;
        entrylo1_i = '0;
        mode_i = '0;
        req0_i = '0;
        req1_i = '0;
        for (int i = 0; i < num_entries; i++) begin
            shadow[i] = '{c0: `MMU_RST_CACHE_ATTR, c1: `MMU_RST_CACHE_ATTR, default: '0};
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check("rsp0_o.hit", rsp0_o.hit, 1'b0);
        check("rsp1_o.hit", rsp1_o.hit, 1'b0);
        for (int i = 0; i < num_entries; i++) begin
            @(negedge clk);
            index_i = i;
            check_readback(i);
        end
        end_test("reset_state");

        for (int i = 0; i < 2 * num_entries; i++) begin
            write_random(i % num_entries);
            check_readback(i % num_entries);
        end
        end_test("write_readback");

        for (int i = 0; i < num_entries; i++) begin
            check_probe(i);
        end
        end_test("probe");

        for (int i = 0; i < n_xlate; i++) begin
            pick0 = rand_bits(`MMU_TLB_IDX_BITS);
            pick1 = rand_bits(`MMU_TLB_IDX_BITS);
            mode_v = '{kernel_mode: 1'b1, erl: 1'b0, kseg0_cached: rand_bits(1)};
            // Mostly the ASID of the port 0 entry and sometimes a stray one
            drive_xlate(mode_v, (rand_bits(2) == 0) ? 8'(rand_bits(8)) : shadow[pick0].asid,
                        mapped_va(pick0), 1'b1, mapped_va(pick1), 1'b1);
        end
        drain();
        end_test("mapped_xlate");

        for (int i = 0; i < 24; i++) begin
            mode_v = '{kernel_mode: i < 16, erl: i >= 8 && i < 16, kseg0_cached: rand_bits(1)};
            va_a = rand_bits(32);
            va_b = rand_bits(32);
            if (i < 8) begin
                va_a[31:29] = 3'b100;
                va_b[31:29] = 3'b101;
            end else begin
                va_a[31] = (i >= 16);
                va_b[31] = (i >= 16);
            end
            drive_xlate(mode_v, entryhi_i[7:0], va_a, 1'b1, va_b, 1'b1);
        end
        drain();
        end_test("unmapped_error");

        mode_v = '{kernel_mode: 1'b1, erl: 1'b0, kseg0_cached: 1'b1};
        va_a = mapped_va(0);
        va_b = mapped_va(1);
        held = xlate_ref(mode_v, va_b, shadow[0].asid);
        drive_xlate(mode_v, shadow[0].asid, va_a, 1'b1, va_b, 1'b1);
        for (int i = 0; i < 8; i++) begin
            drive_xlate(mode_v, shadow[0].asid, mapped_va(i % num_entries), 1'b1,
                        rand_bits(32), 1'b0);
            check("rsp1_o", rsp1_o, held);
        end
        drain();
        check("rsp1_o", rsp1_o, held);
        end_test("hold");

        $display("Tests run: %0d, failed: %0d, check errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, err_total, dut0.u_assert.fail_count);
        if (tests_failed == 0 && err_total == 0 && dut0.u_assert.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- source/addr_xlate.sv
// One address translation port: segment decode, TLB lookup, registered result
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module addr_xlate (
    input  logic                                   clk,
    input  logic                                   rst,
    input  mmu_pkg::xlate_req_t                    req_i,
    input  mmu_pkg::tlb_entry_t [`MMU_TLB_NUM-1:0] entries_i,
    input  logic [7:0]                             asid_i,
    input  mmu_pkg::cp0_mode_t                     mode_i,
    output mmu_pkg::xlate_rsp_t                    rsp_o
);
    import mmu_pkg::*;

    vaddr_u                  va;
    address_segment_t        seg;
    logic                    mapped;
    logic                    addr_err;
    logic [12:0]             sel_bits;
    logic [`MMU_TLB_NUM-1:0] match;
    logic [`MMU_TLB_NUM-1:0] odd_sel;
    logic [11:0]             tlb_mask;
    logic [19:0]             tlb_pfn;
    logic [2:0]              tlb_c;
    logic                    tlb_v;
    logic                    tlb_d;
    xlate_rsp_t              rsp_d;

    assign va = req_i.va;

    // va[24:12], candidates for the even/odd select bit
    assign sel_bits = {va.page_v.vpn2[11:0], va.page_v.odd};

    always_comb begin
        case (va.seg_v.seg)
            3'b100:  seg = kseg0;
            3'b101:  seg = kseg1;
            3'b110:  seg = ksseg;
            3'b111:  seg = kseg3;
            default: seg = useg;
        endcase
    end

    // Kernel segments fault in user mode
    always_comb begin
        mapped   = 1'b0;
        addr_err = 1'b0;
        case (seg)
            useg: begin
                mapped = !(mode_i.kernel_mode && mode_i.erl);
            end
            kseg0, kseg1: begin
                addr_err = !mode_i.kernel_mode;
            end
            default: begin
                mapped   = mode_i.kernel_mode;
                addr_err = !mode_i.kernel_mode;
            end
        endcase
    end

    for (genvar i = 0; i < `MMU_TLB_NUM; i++) begin : g_match
        assign match[i] =
            ((va.page_v.vpn2 & ~{7'b0, entries_i[i].mask}) == entries_i[i].vpn2) &&
            (entries_i[i].g || (entries_i[i].asid == asid_i));
        // Picks out the bit just above the highest mask bit
        assign odd_sel[i] =
            (sel_bits & {entries_i[i].mask, 1'b1}) != (sel_bits & {1'b0, entries_i[i].mask});
    end

    // OR-merge of the single matching entry
    always_comb begin
        tlb_mask = '0;
        tlb_pfn  = '0;
        tlb_c    = '0;
        tlb_v    = 1'b0;
        tlb_d    = 1'b0;
        for (int i = 0; i < `MMU_TLB_NUM; i++) begin
            if (match[i]) begin
                tlb_mask = tlb_mask | entries_i[i].mask;
                tlb_pfn  = tlb_pfn | (odd_sel[i] ? entries_i[i].pfn1 : entries_i[i].pfn0);
                tlb_c    = tlb_c | (odd_sel[i] ? entries_i[i].c1 : entries_i[i].c0);
                tlb_v    = tlb_v | (odd_sel[i] ? entries_i[i].v1 : entries_i[i].v0);
                tlb_d    = tlb_d | (odd_sel[i] ? entries_i[i].d1 : entries_i[i].d0);
            end
        end
    end

    always_comb begin
        rsp_d.vao   = va;
        rsp_d.error = addr_err;
        if (mapped) begin
            // Offset bits inside the mask come from va
            rsp_d.pa = {
                tlb_pfn | ({va.page_v.vpn2, va.page_v.odd} & {8'b0, tlb_mask}),
                va.page_v.page_off
            };
            rsp_d.hit    = |match;
            rsp_d.valid  = tlb_v;
            rsp_d.dirty  = tlb_d;
            rsp_d.cached = (tlb_c == `MMU_CACHE_ATTR_CACHEABLE);
        end else begin
            rsp_d.pa     = {3'b000, va.seg_v.seg_off};
            rsp_d.hit    = 1'b1;
            rsp_d.valid  = 1'b1;
            rsp_d.dirty  = 1'b1;
            rsp_d.cached = (seg == kseg0) && mode_i.kseg0_cached;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_o <= '0;
        end else if (req_i.ce) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

//--- source/mmu_cfg.svh
// MMU configuration macros: TLB size and cache attribute encodings
`ifndef MMU_CFG_SVH
`define MMU_CFG_SVH

// Index width, the TLB holds 2**bits entries
`define MMU_TLB_IDX_BITS 3

// Entry count derived from the index width
`define MMU_TLB_NUM (1 << `MMU_TLB_IDX_BITS)

// Cacheable, noncoherent attribute
`define MMU_CACHE_ATTR_CACHEABLE 3'd3

// Attribute loaded into c0 and c1 by reset
`define MMU_RST_CACHE_ATTR `MMU_CACHE_ATTR_CACHEABLE

`endif

//--- source/mmu_pkg.sv
// MMU types: TLB entry, CP0 mode, translation request/response, virtual address views
`include "mmu_cfg.svh"

package mmu_pkg;

    typedef logic [`MMU_TLB_IDX_BITS-1:0] tlb_idx_t;

    // vpn2 and both pfns held already masked
    typedef struct packed {
        logic [11:0] mask;
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [19:0] pfn1;
        logic [2:0]  c0;
        logic [2:0]  c1;
        logic        d0;
        logic        d1;
        logic        v0;
        logic        v1;
    } tlb_entry_t;

    typedef struct packed {
        logic kernel_mode;
        logic erl;
        logic kseg0_cached;
    } cp0_mode_t;

    typedef struct packed {
        logic [31:0] va;
        logic        ce;
    } xlate_req_t;

    typedef struct packed {
        logic [31:0] vao;
        logic [31:0] pa;
        logic        hit;
        logic        valid;
        logic        dirty;
        logic        cached;
        logic        error;
    } xlate_rsp_t;

    typedef struct packed {
        logic [2:0]  seg;
        logic [28:0] seg_off;
    } vaddr_seg_t;

    // Page view, odd sits right above a 4 KB offset
    typedef struct packed {
        logic [18:0] vpn2;
        logic        odd;
        logic [11:0] page_off;
    } vaddr_page_t;

    typedef union packed {
        vaddr_seg_t  seg_v;
        vaddr_page_t page_v;
    } vaddr_u;

    typedef enum logic [2:0] {
        useg,
        kseg0,
        kseg1,
        ksseg,
        kseg3
    } address_segment_t;

endpackage

//--- source/tlb_entry_array.sv
// TLB entry storage with CP0 write decode and EntryHi/EntryLo read-back
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_entry_array (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   we_i,
    input  mmu_pkg::tlb_idx_t                      index_i,
    input  logic [11:0]                            mask_i,
    input  logic [31:0]                            entryhi_i,
    input  logic [31:0]                            entrylo0_i,
    input  logic [31:0]                            entrylo1_i,
    output mmu_pkg::tlb_entry_t [`MMU_TLB_NUM-1:0] entries_o,
    output logic [11:0]                            mask_o,
    output logic [31:0]                            entryhi_o,
    output logic [31:0]                            entrylo0_o,
    output logic [31:0]                            entrylo1_o
);
    import mmu_pkg::*;

    localparam tlb_entry_t entry_rst = '{
        c0:      `MMU_RST_CACHE_ATTR,
        c1:      `MMU_RST_CACHE_ATTR,
        default: '0
    };

    tlb_entry_t [`MMU_TLB_NUM-1:0] entry_q;
    tlb_entry_t                    wr_entry;
    tlb_entry_t                    rd_entry;

    // Decode CP0 words into one entry
    always_comb begin
        wr_entry.mask = mask_i;
        wr_entry.vpn2 = entryhi_i[31:13] & ~{7'b0, mask_i};
        wr_entry.asid = entryhi_i[7:0];
        // Global only if both halves say so
        wr_entry.g    = entrylo0_i[0] & entrylo1_i[0];
        wr_entry.pfn0 = entrylo0_i[25:6] & ~{8'b0, mask_i};
        wr_entry.pfn1 = entrylo1_i[25:6] & ~{8'b0, mask_i};
        wr_entry.c0   = entrylo0_i[5:3];
        wr_entry.c1   = entrylo1_i[5:3];
        wr_entry.d0   = entrylo0_i[2];
        wr_entry.d1   = entrylo1_i[2];
        wr_entry.v0   = entrylo0_i[1];
        wr_entry.v1   = entrylo1_i[1];
    end

    // TLBWI style write
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MMU_TLB_NUM; i++) begin
                entry_q[i] <= entry_rst;
            end
        end else if (we_i) begin
            entry_q[index_i] <= wr_entry;
        end
    end

    assign entries_o = entry_q;

    // Read-back for TLBR, unused bits zero
    assign rd_entry = entry_q[index_i];

    assign mask_o = rd_entry.mask;

    assign entryhi_o = {rd_entry.vpn2, 5'b0, rd_entry.asid};

    assign entrylo0_o = {
        6'b0,
        rd_entry.pfn0,
        rd_entry.c0,
        rd_entry.d0,
        rd_entry.v0,
        rd_entry.g
    };

    assign entrylo1_o = {
        6'b0,
        rd_entry.pfn1,
        rd_entry.c1,
        rd_entry.d1,
        rd_entry.v1,
        rd_entry.g
    };

endmodule

//--- source/tlb_mmu.sv
// MMU top: TLB entry array, probe and two translation ports
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_mmu (
    input  logic                clk,
    input  logic                rst,
    input  logic                we_i,
    input  logic [31:0]         index_i,
    input  logic [11:0]         mask_i,
    input  logic [31:0]         entryhi_i,
    input  logic [31:0]         entrylo0_i,
    input  logic [31:0]         entrylo1_i,
    input  mmu_pkg::cp0_mode_t  mode_i,
    input  mmu_pkg::xlate_req_t req0_i,
    input  mmu_pkg::xlate_req_t req1_i,
    output logic [11:0]         mask_o,
    output logic [31:0]         entryhi_o,
    output logic [31:0]         entrylo0_o,
    output logic [31:0]         entrylo1_o,
    output logic [31:0]         probe_index_o,
    output mmu_pkg::xlate_rsp_t rsp0_o,
    output mmu_pkg::xlate_rsp_t rsp1_o
);
    import mmu_pkg::*;

    tlb_entry_t [`MMU_TLB_NUM-1:0] entries;

    tlb_entry_array u_array (
        .clk        (clk),
        .rst        (rst),
        .we_i       (we_i),
        .index_i    (index_i[`MMU_TLB_IDX_BITS-1:0]),
        .mask_i     (mask_i),
        .entryhi_i  (entryhi_i),
        .entrylo0_i (entrylo0_i),
        .entrylo1_i (entrylo1_i),
        .entries_o  (entries),
        .mask_o     (mask_o),
        .entryhi_o  (entryhi_o),
        .entrylo0_o (entrylo0_o),
        .entrylo1_o (entrylo1_o)
    );

    tlb_probe u_probe (
        .entries_i     (entries),
        .entryhi_i     (entryhi_i),
        .probe_index_o (probe_index_o)
    );

    // Fetch port
    addr_xlate xlate0 (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req0_i),
        .entries_i (entries),
        .asid_i    (entryhi_i[7:0]),
        .mode_i    (mode_i),
        .rsp_o     (rsp0_o)
    );

    // Data port
    addr_xlate xlate1 (
        .clk       (clk),
        .rst       (rst),
        .req_i     (req1_i),
        .entries_i (entries),
        .asid_i    (entryhi_i[7:0]),
        .mode_i    (mode_i),
        .rsp_o     (rsp1_o)
    );

endmodule

//--- source/tlb_probe.sv
// TLBP probe: parallel EntryHi compare and Index word formatting
`timescale 1ns/1ps
`include "mmu_cfg.svh"

module tlb_probe (
    input  mmu_pkg::tlb_entry_t [`MMU_TLB_NUM-1:0] entries_i,
    input  logic [31:0]                            entryhi_i,
    output logic [31:0]                            probe_index_o
);
    import mmu_pkg::*;

    vaddr_u                  hi;
    logic [7:0]              hi_asid;
    logic [`MMU_TLB_NUM-1:0] match;
    tlb_idx_t                idx_or;

    assign hi      = entryhi_i;
    assign hi_asid = hi.page_v.page_off[7:0];

    for (genvar i = 0; i < `MMU_TLB_NUM; i++) begin : g_cmp
        assign match[i] =
            ((hi.page_v.vpn2 & ~{7'b0, entries_i[i].mask}) == entries_i[i].vpn2) &&
            (entries_i[i].g || (entries_i[i].asid == hi_asid));
    end

    // Entries are unique, so at most one index contributes
    always_comb begin
        idx_or = '0;
        for (int i = 0; i < `MMU_TLB_NUM; i++) begin
            if (match[i]) begin
                idx_or = idx_or | tlb_idx_t'(i);
            end
        end
    end

    // P bit set on a miss
    assign probe_index_o = {~|match, {(31 - `MMU_TLB_IDX_BITS){1'b0}}, idx_or};

endmodule

//--- tlb_mmu.f
+incdir+source
source/mmu_pkg.sv
source/tlb_entry_array.sv
source/tlb_probe.sv
source/addr_xlate.sv
source/tlb_mmu.sv
dv/tlb_mmu_assert.sv
dv/tlb_mmu_tb.sv
